// File: Makefile
VERILATOR ?= verilator
FILELIST ?= project.f
TOP ?= vgaTextTb
RTL_TOP ?= vgaText
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/cellMemory.sv
`timescale 1ns/1ps

module cellMemory
	import vgaTextPkg::*;
(
	input logic VGA_CLK,
	input logic reset,
	input cellWrite writeIn,
	input beamPos beamIn,
	output cellAttr cellOut,
	output beamPos beamOut
);

	cellAttr cells [cellCount];

	logic [rowAddrW-1:0] writeRow;
	logic writeOk;
	logic [cellAddrW-1:0] readAddr;

	// Screen starts blank
	initial begin
		for (int i = 0; i < cellCount; i++) begin
			cells[i] = '0;
		end
	end

	// Column field is 6 bits, so only the row can fall outside the grid
	assign writeRow = writeIn.addr[cellAddrW-1:colAddrW];
	assign writeOk = writeIn.valid && (writeRow < rowAddrW'(textRows));

	always_ff @(posedge VGA_CLK) begin
		if (writeOk) begin
			cells[writeIn.addr] <= writeIn.attr;
		end
	end

	assign readAddr = {beamIn.textRow[rowAddrW-1:0], beamIn.textCol[colAddrW-1:0]};

	// Old contents win on a same-cycle collision
	always_ff @(posedge VGA_CLK) begin
		if (beamIn.inText) begin
			cellOut <= cells[readAddr];
		end else begin
			cellOut <= '0;
		end
	end

	// Beam travels alongside the read data
	always_ff @(posedge VGA_CLK or negedge reset) begin
		if (!reset) begin
			beamOut <= beamIdle;
		end else begin
			beamOut <= beamIn;
		end
	end

endmodule

// File: design/glyphRenderer.sv
`timescale 1ns/1ps

module glyphRenderer
	import vgaTextPkg::*;
(
	input logic VGA_CLK,
	input logic reset,
	input cellAttr cellIn,
	input beamPos beamIn,
	output logic VGA_HS,
	output logic VGA_VS,
	output logic VGA_BLANK_N,
	output logic [7:0] VGA_R,
	output logic [7:0] VGA_G,
	output logic [7:0] VGA_B
);

	// Bit 0 is the top left pixel of the glyph
	logic [0:glyphBits-1] fontRom [fontCount];

	initial begin
		$readmemh(fontFile, fontRom);
	end

	logic [7:0] fontOffset;
	logic [fontIdxW-1:0] fontIdx;
	logic inFont;
	logic [0:glyphBits-1] glyphWord;
	logic [glyphYW+glyphXW-1:0] bitIdx;
	logic pixelOn;
	colourIdx pixelColour;

	always_comb begin
		// Codes below the font wrap to large offsets
		fontOffset = cellIn.code - fontFirst;
		fontIdx = fontOffset[fontIdxW-1:0];
		inFont = (fontOffset < 8'(fontCount));
		glyphWord = fontRom[fontIdx];
		bitIdx = {beamIn.glyphY, beamIn.glyphX};
		pixelOn = inFont && glyphWord[bitIdx];
	end

	always_comb begin
		if (!beamIn.displayEn) begin
			pixelColour = '0; // Blanking
		end else if (pixelOn) begin
			pixelColour = cellIn.fgColour;
		end else begin
			pixelColour = cellIn.bgColour;
		end
	end

	always_ff @(posedge VGA_CLK or negedge reset) begin
		if (!reset) begin
			VGA_HS <= 1'b1;
			VGA_VS <= 1'b1;
			VGA_BLANK_N <= 1'b0;
			VGA_R <= 8'h00;
			VGA_G <= 8'h00;
			VGA_B <= 8'h00;
		end else begin
			VGA_HS <= beamIn.hSyncN;
			VGA_VS <= beamIn.vSyncN;
			VGA_BLANK_N <= beamIn.displayEn;
			VGA_R <= expandChannel(pixelColour.red);
			VGA_G <= expandChannel(pixelColour.green);
			VGA_B <= expandChannel(pixelColour.blue);
		end
	end

endmodule

// File: design/syncTimer.sv
`timescale 1ns/1ps

module syncTimer
	import vgaTextPkg::*;
(
	input logic VGA_CLK,
	input logic reset,
	output beamPos beam
);

	localparam logic [hCountW-1:0] hSyncStart = hActive + hFront;
	localparam logic [hCountW-1:0] hSyncEnd = hActive + hFront + hSync;
	localparam logic [vCountW-1:0] vSyncStart = vActive + vFront;
	localparam logic [vCountW-1:0] vSyncEnd = vActive + vFront + vSync;

	logic [hCountW-1:0] hCount;
	logic [vCountW-1:0] vCount;
	logic [textColW-1:0] textCol;
	logic [textRowW-1:0] textRow;
	logic [glyphXW-1:0] glyphX;
	logic [glyphYW-1:0] glyphY;
	logic lastPixel;
	logic lastLine;
	logic displayEn;

	assign lastPixel = (hCount == hTotal - 1'b1);
	assign lastLine = (vCount == vTotal - 1'b1);

	always_ff @(posedge VGA_CLK or negedge reset) begin
		if (!reset) begin
			hCount <= '0;
			vCount <= '0;
			textCol <= '0;
			textRow <= '0;
			glyphX <= '0;
			glyphY <= '0;
		end else if (lastPixel) begin
			// Next line
			hCount <= '0;
			textCol <= '0;
			glyphX <= '0;
			if (lastLine) begin
				vCount <= '0;
				textRow <= '0;
				glyphY <= '0;
			end else begin
				vCount <= vCount + 1'b1;
				if (glyphY == glyphYW'(glyphHeight - 1)) begin
					glyphY <= '0;
					textRow <= textRow + 1'b1;
				end else begin
					glyphY <= glyphY + 1'b1;
				end
			end
		end else begin
			hCount <= hCount + 1'b1;
			if (glyphX == glyphXW'(glyphWidth - 1)) begin
				glyphX <= '0;
				textCol <= textCol + 1'b1;
			end else begin
				glyphX <= glyphX + 1'b1;
			end
		end
	end

	assign displayEn = (hCount < hActive) && (vCount < vActive);

	always_comb begin
		beam.textCol = textCol;
		beam.textRow = textRow;
		beam.glyphX = glyphX;
		beam.glyphY = glyphY;
		beam.displayEn = displayEn;
		beam.inText = displayEn && (textCol < textColW'(textCols))
			&& (textRow < textRowW'(textRows));
		beam.hSyncN = !((hCount >= hSyncStart) && (hCount < hSyncEnd)); // Low 656..751
		beam.vSyncN = !((vCount >= vSyncStart) && (vCount < vSyncEnd)); // Low 490..491
	end

endmodule

// File: design/vgaText.sv
`timescale 1ns/1ps

module vgaText
	import vgaTextPkg::*;
(
	input logic VGA_CLK,
	input logic reset,
	input cellWrite writeIn,
	output logic VGA_HS,
	output logic VGA_VS,
	output logic VGA_BLANK_N,
	output logic [7:0] VGA_R,
	output logic [7:0] VGA_G,
	output logic [7:0] VGA_B
);

	beamPos timerBeam; // Counters, combinational
	beamPos memBeam;   // One cycle later
	cellAttr memCell;

	syncTimer syncTimer_i (
		.VGA_CLK(VGA_CLK),
		.reset(reset),
		.beam(timerBeam)
	);

	cellMemory cellMemory_i (
		.VGA_CLK(VGA_CLK),
		.reset(reset),
		.writeIn(writeIn),
		.beamIn(timerBeam),
		.cellOut(memCell),
		.beamOut(memBeam)
	);

	// Registers the outputs, two cycles after the counters
	glyphRenderer glyphRenderer_i (
		.VGA_CLK(VGA_CLK),
		.reset(reset),
		.cellIn(memCell),
		.beamIn(memBeam),
		.VGA_HS(VGA_HS),
		.VGA_VS(VGA_VS),
		.VGA_BLANK_N(VGA_BLANK_N),
		.VGA_R(VGA_R),
		.VGA_G(VGA_G),
		.VGA_B(VGA_B)
	);

endmodule

// File: design/vgaTextPkg.sv
package vgaTextPkg;

	// Horizontal timing in pixels
	localparam int hCountW = 10;
	localparam logic [hCountW-1:0] hActive = 10'd640;
	localparam logic [hCountW-1:0] hFront = 10'd16;
	localparam logic [hCountW-1:0] hSync = 10'd96;
	localparam logic [hCountW-1:0] hBack = 10'd48;
	localparam logic [hCountW-1:0] hTotal = hActive + hFront + hSync + hBack; // 800

	// Vertical timing in lines
	localparam int vCountW = 10;
	localparam logic [vCountW-1:0] vActive = 10'd480;
	localparam logic [vCountW-1:0] vFront = 10'd10;
	localparam logic [vCountW-1:0] vSync = 10'd2;
	localparam logic [vCountW-1:0] vBack = 10'd33;
	localparam logic [vCountW-1:0] vTotal = vActive + vFront + vSync + vBack; // 525

	// Character grid
	localparam int textCols = 64;
	localparam int textRows = 40;
	localparam int cellCount = textCols * textRows;
	localparam int colAddrW = $clog2(textCols);
	localparam int rowAddrW = $clog2(textRows);
	localparam int cellAddrW = rowAddrW + colAddrW;
	localparam int textColW = 7; // Counts up to 99 across the full line
	localparam int textRowW = 6; // Counts up to 43 across the full frame

	// Glyph cell
	localparam int glyphWidth = 8;
	localparam int glyphHeight = 12;
	localparam int glyphXW = $clog2(glyphWidth);
	localparam int glyphYW = $clog2(glyphHeight);
	localparam int glyphBits = glyphWidth * glyphHeight;

	// Reduced font, codes 0x20 to 0x3F only
	localparam logic [7:0] fontFirst = 8'h20;
	localparam int fontCount = 32;
	localparam int fontIdxW = $clog2(fontCount);
	localparam string fontFile = "fontGlyphs.hex";

	typedef struct packed {
		logic red;
		logic green;
		logic blue;
	} colourIdx;

	// Code in the low byte
	typedef struct packed {
		colourIdx fgColour;
		colourIdx bgColour;
		logic [7:0] code;
	} cellAttr;

	typedef struct packed {
		logic valid;
		logic [cellAddrW-1:0] addr; // {row, col}
		cellAttr attr;
	} cellWrite;

	typedef struct packed {
		logic [textColW-1:0] textCol;
		logic [textRowW-1:0] textRow;
		logic [glyphXW-1:0] glyphX;
		logic [glyphYW-1:0] glyphY;
		logic inText;
		logic displayEn;
		logic hSyncN;
		logic vSyncN;
	} beamPos;

	// Beam state with both syncs idle and nothing visible
	localparam beamPos beamIdle = '{hSyncN: 1'b1, vSyncN: 1'b1, default: '0};

	function automatic logic [7:0] expandChannel(input logic on);
		return on ? 8'hFF : 8'h00;
	endfunction

endpackage

// File: fontGlyphs.hex
// One glyph per line for codes 0x20 to 0x3F, 12 rows of 8 pixels
// Leftmost byte is the top row, most significant bit of each byte is the left pixel
000000000000000000000000
001818181818180018180000
006C6C240000000000000000
006C6CFE6C6CFE6C6C000000
187CC6C07C06C67C18180000
00C6CC183066C60000000000
00386C3876DCCC7600000000
001818300000000000000000
000C1830303030180C000000
0030180C0C0C0C1830000000
0000663CFF3C660000000000
000018187E18180000000000
000000000000001818300000
000000007E00000000000000
000000000000001818000000
00060C183060C00000000000
007CC6CEDEF6E6C67C000000
00183878181818187E000000
007CC6060C183060FE000000
007CC6063C0606C67C000000
000C1C3C6CCCFE0C0C000000
00FEC0C0FC0606C67C000000
003860C0FCC6C6C67C000000
00FEC6060C18303030000000
007CC6C67CC6C6C67C000000
007CC6C67E06060C78000000
000018180000181800000000
000018180000181830000000
00060C18306030180C060000
0000007E00007E0000000000
006030180C060C1830600000
007CC6C60C18180018180000

// File: project.f
+incdir+include
design/vgaTextPkg.sv
design/syncTimer.sv
design/cellMemory.sv
design/glyphRenderer.sv
design/vgaText.sv
verification/vgaTextTb.sv

// File: include/vgaTextModel.svh
`ifndef VGA_TEXT_MODEL_SVH
`define VGA_TEXT_MODEL_SVH

typedef struct packed {
	logic hs;
	logic vs;
	logic blankN;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
} vgaSample;

cellAttr modelCells [cellCount];
logic [0:glyphBits-1] modelFont [fontCount];

function automatic void clearModel();
	for (int i = 0; i < cellCount; i++) begin
		modelCells[i] = '0;
	end
	$readmemh(fontFile, modelFont);
endfunction

// Rows 40 and up fall outside the grid
function automatic void mirrorWrite(input cellWrite w);
	if (w.valid && (w.addr[11:6] < 6'd40)) begin
		modelCells[w.addr] = w.attr;
	end
endfunction

function automatic vgaSample idleSample();
	vgaSample s;
	s = '0;
	s.hs = 1'b1;
	s.vs = 1'b1;
	return s;
endfunction

function automatic vgaSample predictPixel(input int h, input int v);
	vgaSample s;
	cellAttr a;
	colourIdx colour;
	int col;
	int row;
	int glyphIdx;
	logic bitOn;
	s.hs = !((h >= 656) && (h < 752));
	s.vs = !((v >= 490) && (v < 492));
	s.blankN = (h < 640) && (v < 480);
	colour = '0;
	col = h / 8;
	row = v / 12;
	if (s.blankN && (col < 64) && (row < 40)) begin
		a = modelCells[row * 64 + col];
		bitOn = 1'b0;
		if ((a.code >= 8'h20) && (a.code <= 8'h3F)) begin
			glyphIdx = int'(a.code) - 32;
			bitOn = modelFont[glyphIdx][(v % 12) * 8 + (h % 8)]; // MSB is the left pixel
		end
		colour = bitOn ? a.fgColour : a.bgColour;
	end
	s.r = colour.red ? 8'hFF : 8'h00;
	s.g = colour.green ? 8'hFF : 8'h00;
	s.b = colour.blue ? 8'hFF : 8'h00;
	return s;
endfunction

`endif

// File: verification/vgaTextTb.sv
`timescale 1ns/1ps

module vgaTextTb
	import vgaTextPkg::*;
;

	localparam int framePixels = 800 * 525;
	localparam int frameCount = 3;
	localparam int timeoutCycles = 16 + 2 + frameCount * framePixels + 5000;
	localparam int printLimit = 50;

	logic VGA_CLK;
	logic reset;
	cellWrite writeIn;
	logic VGA_HS;
	logic VGA_VS;
	logic VGA_BLANK_N;
	logic [7:0] VGA_R;
	logic [7:0] VGA_G;
	logic [7:0] VGA_B;

	logic [31:0] rngState = 32'h3da0_c51a;
	int errors [5];
	int printedLines = 0;
	string testNames [5] = '{"reset", "sync", "blanking", "render", "rewrite"};

	`include "vgaTextModel.svh"

	vgaText vgaText_i (
		.VGA_CLK(VGA_CLK),
		.reset(reset),
		.writeIn(writeIn),
		.VGA_HS(VGA_HS),
		.VGA_VS(VGA_VS),
		.VGA_BLANK_N(VGA_BLANK_N),
		.VGA_R(VGA_R),
		.VGA_G(VGA_G),
		.VGA_B(VGA_B)
	);

	initial begin
		VGA_CLK = 1'b0;
		forever #5 VGA_CLK = ~VGA_CLK;
	end

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic cellWrite randomWrite();
		cellWrite w;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [5:0] row;
		r1 = nextRandom();
		r2 = nextRandom();
		r3 = nextRandom();
		// Fields use the upper bits where the LCG period is long
		if (r1[31:28] == 4'd0) begin
			row = 6'd40 + 6'(r1[27:8] % 24); // Off the grid
		end else begin
			row = 6'(r1[27:8] % 40);
		end
		w.valid = (r2[31:29] != 3'd0);
		w.addr = {row, r3[31:26]};
		w.attr.code = r2[28] ? (8'h20 + {3'b000, r2[27:23]}) : r2[27:20];
		w.attr.bgColour = r2[19:17];
		w.attr.fgColour = r2[16:14];
		return w;
	endfunction

	function automatic vgaSample sampleOutputs();
		vgaSample s;
		s.hs = VGA_HS;
		s.vs = VGA_VS;
		s.blankN = VGA_BLANK_N;
		s.r = VGA_R;
		s.g = VGA_G;
		s.b = VGA_B;
		return s;
	endfunction

	task automatic reportMismatch(input int test, input string name, input logic [31:0] gotVal,
		input logic [31:0] expVal, input int n);
		errors[test]++;
		if (printedLines < printLimit) begin
			$display("MISMATCH %s at pixel %0d: got %h expected %h", name, n, gotVal, expVal);
			printedLines++;
		end
	endtask

	task automatic reportFailure(input int test, input string msg);
		errors[test]++;
		if (printedLines < printLimit) begin
			$display("%s", msg);
			printedLines++;
		end
	endtask

	task automatic compareOutputs(input int test, input vgaSample exp, input int n);
		vgaSample got;
		got = sampleOutputs();
		assert (got.hs == exp.hs) else reportMismatch(test, "VGA_HS", 32'(got.hs), 32'(exp.hs), n);
		assert (got.vs == exp.vs) else reportMismatch(test, "VGA_VS", 32'(got.vs), 32'(exp.vs), n);
		assert (got.blankN == exp.blankN)
			else reportMismatch(test, "VGA_BLANK_N", 32'(got.blankN), 32'(exp.blankN), n);
		assert (got.r == exp.r) else reportMismatch(test, "VGA_R", 32'(got.r), 32'(exp.r), n);
		assert (got.g == exp.g) else reportMismatch(test, "VGA_G", 32'(got.g), 32'(exp.g), n);
		assert (got.b == exp.b) else reportMismatch(test, "VGA_B", 32'(got.b), 32'(exp.b), n);
	endtask

	task automatic reportTest(input int test);
		$display("Test %s: %s, %0d errors", testNames[test], (errors[test] == 0) ? "ok" : "FAILED",
			errors[test]);
	endtask

	task automatic sendWrites(input int count);
		cellWrite w;
		for (int i = 0; i < count; i++) begin
			w = randomWrite();
			writeIn <= w;
			mirrorWrite(w); // Takes effect at the next edge
			@(posedge VGA_CLK);
		end
		writeIn <= '0;
	endtask

	// Starts on the edge that releases reset; writes land only in vertical blanking
	task automatic driveWrites();
		repeat (481 * 800) @(posedge VGA_CLK);
		sendWrites(3000);
		repeat (framePixels - 3000) @(posedge VGA_CLK);
		sendWrites(1500);
	endtask

	task automatic runChecks();
		vgaSample got;
		int frame;
		int p;
		int h;
		int v;
		int hsLowRun;
		int lastHsFall;
		int vsLowCount;
		int lastVsFall;
		int blankRun;
		logic prevHs;
		logic prevVs;
		hsLowRun = 0;
		lastHsFall = -1;
		vsLowCount = 0;
		lastVsFall = -1;
		blankRun = 0;
		prevHs = 1'b1;
		prevVs = 1'b1;
		for (int n = 0; n < frameCount * framePixels; n++) begin
			@(negedge VGA_CLK);
			frame = n / framePixels;
			p = n % framePixels;
			v = p / 800;
			h = p % 800;
			compareOutputs(frame + 2, predictPixel(h, v), n);
			got = sampleOutputs();
			if (frame < 2) begin
				if (!got.hs) hsLowRun++;
				if (prevHs && !got.hs) begin
					assert ((lastHsFall < 0) || (n - lastHsFall == 800)) else
						reportFailure(1, $sformatf("HS period was %0d cycles instead of 800",
							n - lastHsFall));
					lastHsFall = n;
				end
				if (!prevHs && got.hs) begin
					assert (hsLowRun == 96) else
						reportFailure(1, $sformatf("HS low pulse lasted %0d cycles", hsLowRun));
					hsLowRun = 0;
				end
				if (!got.vs) vsLowCount++;
				if (prevVs && !got.vs) begin
					assert ((lastVsFall < 0) || (n - lastVsFall == framePixels)) else
						reportFailure(1, $sformatf("Frame lasted %0d cycles", n - lastVsFall));
					lastVsFall = n;
				end
			end
			if (frame < 2) begin
				blankRun += got.blankN;
				assert (got.blankN || ({got.r, got.g, got.b} == '0)) else
					reportFailure(2, $sformatf("RGB not black during blanking at pixel %0d", n));
				if (h == 799) begin
					assert (blankRun == ((v < 480) ? 640 : 0)) else
						reportFailure(2, $sformatf("Line %0d had %0d visible pixels", v, blankRun));
					blankRun = 0;
				end
			end
			prevHs = got.hs;
			prevVs = got.vs;
			if (p == framePixels - 1) begin
				if (frame < 2) begin
					assert (vsLowCount == 1600) else
						reportFailure(1, $sformatf("VS was low for %0d cycles", vsLowCount));
					vsLowCount = 0;
				end
				if (frame == 1) begin
					assert (lastVsFall >= 0) else reportFailure(1, "No VS pulse was seen");
					reportTest(1);
					reportTest(2);
					reportTest(3);
				end
				if (frame == 2) reportTest(4);
			end
		end
	endtask

	initial begin
		int total;
		reset = 1'b0;
		writeIn = '0;
		clearModel();
		repeat (16) begin
			@(negedge VGA_CLK);
			compareOutputs(0, idleSample(), -1);
		end
		@(posedge VGA_CLK);
		reset <= 1'b1;
		fork
			driveWrites();
			begin
				repeat (2) begin
					@(negedge VGA_CLK);
					compareOutputs(0, idleSample(), -1); // Pipeline still filling
				end
				reportTest(0);
				runChecks();
			end
		join
		total = 0;
		foreach (errors[i]) total += errors[i];
		$display("Tests run: 5, errors: %0d", total);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (timeoutCycles) @(posedge VGA_CLK);
		$display("Watchdog expired before all frames were checked");
		$display("sim failed");
		$finish;
	end

endmodule
